// ==== tests/stim_input.txt ====
I FILL 00001000 2 00000000 1
D STORE 00002000 2 cafef00d 2
I NC 00001014 2 00000000 3
D LOAD 00002000 2 00000000 4
D STORE 00002005 0 0000ab00 5
D STORE 00002006 1 12340000 6
I FILL 00001028 2 00000000 7
D LOAD 00002004 2 00000000 8
D STORE 00002008 0 000000ee 9
D STORE 0000200b 0 99000000 a
D STORE 0000200c 1 00005678 b
I NC 0000103c 2 00000000 c
D LOAD 00002008 2 00000000 d
D LOAD 0000200c 2 00000000 e
I FILL 00001040 2 00000000 f
D LOAD 00002010 2 00000000 0

// ==== cache_bus_adapter.f ====
verilog/cache_bus_pkg.sv
verilog/req_fifo.sv
verilog/req_arbiter.sv
verilog/wb_master.sv
verilog/rtrn_assembler.sv
verilog/cache_bus_adapter.sv
tests/wb_mem_model.sv
tests/tb_cache_bus_adapter.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache bus adapter testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps -j 0 \
  --top-module tb_cache_bus_adapter -f cache_bus_adapter.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tests/tb_cache_bus_adapter.sv ====
`timescale 1ns/100ps

module tb_cache_bus_adapter;
  import cache_bus_pkg::*;

  localparam int MaxTests = 64;
  localparam logic [15:0] LfsrSeed = 16'd34511;

  typedef enum int {OP_FILL, OP_NC, OP_LOAD, OP_STORE} stim_op_e;

  logic              clk;
  logic              rst_n;
  logic              ic_req;
  logic              ic_ack;
  icache_req_t       ic_data;
  logic              ic_vld;
  icache_rtrn_t      ic_rtrn;
  logic              dc_req;
  logic              dc_ack;
  dcache_req_t       dc_data;
  logic              dc_vld;
  dcache_rtrn_t      dc_rtrn;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;
  logic [1:0]        ack_delay;

  // one entry per line of the stimulus file
  logic              is_dc_a [MaxTests];
  stim_op_e          op_a    [MaxTests];
  logic [ADDR_W-1:0] addr_a  [MaxTests];
  logic [1:0]        size_a  [MaxTests];
  logic [DATA_W-1:0] data_a  [MaxTests];
  logic [TID_W-1:0]  tid_a   [MaxTests];

  logic [DATA_W-1:0] mirror [logic [ADDR_W-1:0]];
  int                ic_exp [$];
  int                dc_exp [$];
  int                n_tests = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                err_cnt = 0;
  int                rtrn_cnt = 0;
  int                stall_cnt = 0;
  int                ack_draw;
  logic [15:0]       ack_lfsr = LfsrSeed;
  logic              loaded = 1'b0;

  cache_bus_adapter #(
    .ReqFifoDepth(REQ_FIFO_DEPTH)
  ) dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .icache_req_i     (ic_req),
    .icache_ack_o     (ic_ack),
    .icache_data_i    (ic_data),
    .icache_rtrn_vld_o(ic_vld),
    .icache_rtrn_o    (ic_rtrn),
    .dcache_req_i     (dc_req),
    .dcache_ack_o     (dc_ack),
    .dcache_data_i    (dc_data),
    .dcache_rtrn_vld_o(dc_vld),
    .dcache_rtrn_o    (dc_rtrn),
    .wb_o             (wb_req),
    .wb_i             (wb_rsp)
  );

  wb_mem_model i_mem (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .wb_i   (wb_req),
    .wb_o   (wb_rsp),
    .delay_i(ack_delay)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(inout logic [15:0] state, input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      state = lfsr_step(state);
      val = (val << 1) | int'(state[0]);
    end
  endtask

  function automatic logic [DATA_W-1:0] mirror_word(input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] key;
    key = a & ~ADDR_W'(3);
    if (mirror.exists(key)) begin
      return mirror[key];
    end
    return key ^ 32'h5A5A0000;
  endfunction

  // byte lanes a store of this size touches at this offset
  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] off);
    case (size)
      2'd0: return 4'b0001 << off;
      2'd1: return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic void apply_store(input int idx);
    logic [ADDR_W-1:0] key;
    logic [DATA_W-1:0] word;
    logic [3:0]        lanes;
    key   = addr_a[idx] & ~ADDR_W'(3);
    word  = mirror_word(key);
    lanes = lane_mask(size_a[idx], addr_a[idx][1:0]);
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        word[8*b +: 8] = data_a[idx][8*b +: 8];
      end
    end
    mirror[key] = word;
  endfunction

  function automatic string test_name(input int idx);
    return $sformatf("t%0d_%s", idx + 1, op_a[idx].name());
  endfunction

  function automatic void report_test(input string name, input logic ok);
    if (ok) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed", name);
    end
  endfunction

  task automatic read_stimulus();
    int          fd;
    int          code;
    int          size_v;
    logic [7:0]  port_s;
    logic [47:0] op_s;
    logic [31:0] addr_v;
    logic [31:0] data_v;
    logic [31:0] tid_v;
    fd = $fopen("tests/stim_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/stim_input.txt");
      err_cnt++;
      return;
    end
    while (!$feof(fd) && n_tests < MaxTests) begin
      code = $fscanf(fd, "%s %s %h %d %h %h\n", port_s, op_s, addr_v, size_v, data_v, tid_v);
      if (code != 6) begin
        break;
      end
      if (op_s == 48'("FILL")) begin
        op_a[n_tests] = OP_FILL;
      end else if (op_s == 48'("NC")) begin
        op_a[n_tests] = OP_NC;
      end else if (op_s == 48'("LOAD")) begin
        op_a[n_tests] = OP_LOAD;
      end else if (op_s == 48'("STORE")) begin
        op_a[n_tests] = OP_STORE;
      end else begin
        $display("unknown operation in stimulus line %0d", n_tests + 1);
        err_cnt++;
        continue;
      end
      is_dc_a[n_tests] = (port_s == 8'("D"));
      addr_a[n_tests]  = addr_v;
      size_a[n_tests]  = size_v[1:0];
      data_a[n_tests]  = data_v;
      tid_a[n_tests]   = tid_v[TID_W-1:0];
      n_tests++;
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // request drivers
  ////////////////////////////////////////////////////////////

  task automatic drive_icache();
    logic [15:0] lfsr;
    int          gap;
    icache_req_t req;
    lfsr = LfsrSeed;
    for (int k = 0; k < n_tests; k++) begin
      if (!is_dc_a[k]) begin
        draw_bits(lfsr, 2, gap);
        if (gap > 0) begin
          ic_req <= 1'b0;
          repeat (gap) @(posedge clk);
        end
        req.paddr = addr_a[k];
        req.nc    = (op_a[k] == OP_NC);
        req.tid   = tid_a[k];
        ic_req  <= 1'b1;
        ic_data <= req;
        @(posedge clk);
        while (!ic_ack) begin
          stall_cnt++;
          @(posedge clk);
        end
        ic_exp.push_back(k);
      end
    end
    ic_req <= 1'b0;
  endtask

  task automatic drive_dcache();
    logic [15:0] lfsr;
    int          gap;
    dcache_req_t req;
    lfsr = LfsrSeed;
    for (int k = 0; k < n_tests; k++) begin
      if (is_dc_a[k]) begin
        draw_bits(lfsr, 2, gap);
        if (gap > 0) begin
          dc_req <= 1'b0;
          repeat (gap) @(posedge clk);
        end
        req.rtype = (op_a[k] == OP_STORE) ? DC_STORE : DC_LOAD;
        req.paddr = addr_a[k];
        req.size  = size_a[k];
        req.data  = data_a[k];
        req.tid   = tid_a[k];
        dc_req  <= 1'b1;
        dc_data <= req;
        @(posedge clk);
        while (!dc_ack) begin
          stall_cnt++;
          @(posedge clk);
        end
        dc_exp.push_back(k);
      end
    end
    dc_req <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // return checks
  ////////////////////////////////////////////////////////////

  task automatic check_icache_return();
    int                idx;
    logic              ok;
    logic [LINE_W-1:0] exp_line;
    logic [ADDR_W-1:0] base;
    if (ic_exp.size() == 0) begin
      $display("instruction cache return arrived with no request outstanding");
      err_cnt++;
      return;
    end
    idx = ic_exp.pop_front();
    ok = 1'b1;
    exp_line = '0;
    if (op_a[idx] == OP_FILL) begin
      base = addr_a[idx] & ~ADDR_W'(LINE_W / 8 - 1);
      for (int i = 0; i < LINE_WORDS; i++) begin
        exp_line[DATA_W*i +: DATA_W] = mirror_word(base + ADDR_W'(4 * i));
      end
    end else begin
      exp_line[DATA_W-1:0] = mirror_word(addr_a[idx]);
    end
    if (ic_rtrn.tid !== tid_a[idx]) begin
      $display("FAILED %s tid: expected %h actual %h", test_name(idx), tid_a[idx], ic_rtrn.tid);
      ok = 1'b0;
    end
    if (ic_rtrn.data !== exp_line) begin
      $display("FAILED %s data: expected %h actual %h", test_name(idx), exp_line, ic_rtrn.data);
      ok = 1'b0;
    end
    rtrn_cnt++;
    report_test(test_name(idx), ok);
  endtask

  task automatic check_dcache_return();
    int                idx;
    logic              ok;
    logic [LINE_W-1:0] exp_line;
    dcache_ack_e       exp_type;
    if (dc_exp.size() == 0) begin
      $display("data cache return arrived with no request outstanding");
      err_cnt++;
      return;
    end
    idx = dc_exp.pop_front();
    ok = 1'b1;
    exp_line = '0;
    exp_type = (op_a[idx] == OP_STORE) ? DC_STORE_ACK : DC_LOAD_ACK;
    if (dc_rtrn.rtype !== exp_type) begin
      $display("FAILED %s rtype: expected %s actual %s", test_name(idx), exp_type.name(),
               dc_rtrn.rtype.name());
      ok = 1'b0;
    end
    if (dc_rtrn.tid !== tid_a[idx]) begin
      $display("FAILED %s tid: expected %h actual %h", test_name(idx), tid_a[idx], dc_rtrn.tid);
      ok = 1'b0;
    end
    if (op_a[idx] == OP_STORE) begin
      apply_store(idx);
    end else begin
      exp_line[DATA_W-1:0] = mirror_word(addr_a[idx]);
      if (dc_rtrn.data !== exp_line) begin
        $display("FAILED %s data: expected %h actual %h", test_name(idx), exp_line, dc_rtrn.data);
        ok = 1'b0;
      end
    end
    rtrn_cnt++;
    report_test(test_name(idx), ok);
  endtask

  // vld, cyc and both acks must stay low until the first request
  task automatic check_reset_idle();
    logic [4:0] seen;
    logic       ok;
    ok = 1'b1;
    repeat (4) begin
      @(posedge clk);
      seen = {ic_vld, dc_vld, wb_req.cyc, ic_ack, dc_ack};
      if (seen !== 5'b00000) begin
        $display("FAILED reset_idle: expected %b actual %b", 5'b00000, seen);
        ok = 1'b0;
      end
    end
    report_test("reset_idle", ok);
  endtask

  always @(posedge clk) begin : rtrn_monitor
    if (ic_vld) begin
      check_icache_return();
    end
    if (dc_vld) begin
      check_dcache_return();
    end
  end

  // new slave delay after every acked beat
  always @(posedge clk) begin : ack_delay_gen
    if (wb_rsp.ack) begin
      draw_bits(ack_lfsr, 2, ack_draw);
      ack_delay <= ack_draw[1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    ic_req    <= 1'b0;
    ic_data   <= '0;
    dc_req    <= 1'b0;
    dc_data   <= '0;
    ack_delay <= 2'd0;
    rst_n     <= 1'b0;
    read_stimulus();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_idle();
    loaded = 1'b1;
    fork
      drive_icache();
      drive_dcache();
    join
    wait (rtrn_cnt == n_tests);
    repeat (4) @(posedge clk);
    if (stall_cnt == 0) begin
      $display("backpressure: no request ever had to wait for its ack");
    end
    report_test("backpressure", stall_cnt > 0);
    $display("tests passed %0d, failed %0d, other errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_tests * 200 + 20) @(posedge clk);
    $display("timeout: %0d of %0d returns never arrived", n_tests - rtrn_cnt, n_tests);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== tests/wb_mem_model.sv ====
`timescale 1ns/100ps

module wb_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  cache_bus_pkg::wb_req_t wb_i,
  output cache_bus_pkg::wb_rsp_t wb_o,
  input  logic [1:0]             delay_i
);
  import cache_bus_pkg::*;

  logic [DATA_W-1:0] mem_q [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] word_adr;
  logic [1:0]        wait_q;
  logic              ack_q;
  logic [DATA_W-1:0] dat_q;

  assign word_adr = wb_i.adr & ~ADDR_W'(3);
  assign wb_o.ack = ack_q;
  assign wb_o.dat = dat_q;

  // untouched words read back as their address with a marker in the upper half
  function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] adr);
    if (mem_q.exists(adr)) begin
      return mem_q[adr];
    end
    return adr ^ 32'h5A5A0000;
  endfunction

  // registered ack, delay_i adds 0 to 3 wait cycles per beat
  always @(posedge clk_i or negedge rst_ni) begin : p_slave
    logic [DATA_W-1:0] word;
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      wait_q <= '0;
      dat_q  <= '0;
    end else if (ack_q) begin
      ack_q  <= 1'b0;
      wait_q <= '0;
    end else if (wb_i.cyc && wb_i.stb) begin
      if (wait_q >= delay_i) begin
        word = read_word(word_adr);
        ack_q <= 1'b1;
        dat_q <= word;
        if (wb_i.we) begin
          for (int b = 0; b < SEL_W; b++) begin
            if (wb_i.sel[b]) begin
              word[8*b +: 8] = wb_i.dat[8*b +: 8];
            end
          end
          mem_q[word_adr] = word;
        end
      end else begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

endmodule

// ==== verilog/cache_bus_adapter.sv ====
`timescale 1ns/100ps

module cache_bus_adapter #(
  parameter int unsigned ReqFifoDepth = cache_bus_pkg::REQ_FIFO_DEPTH
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // instruction cache
  input  logic                        icache_req_i,
  output logic                        icache_ack_o,
  input  cache_bus_pkg::icache_req_t  icache_data_i,
  output logic                        icache_rtrn_vld_o,
  output cache_bus_pkg::icache_rtrn_t icache_rtrn_o,
  // data cache
  input  logic                        dcache_req_i,
  output logic                        dcache_ack_o,
  input  cache_bus_pkg::dcache_req_t  dcache_data_i,
  output logic                        dcache_rtrn_vld_o,
  output cache_bus_pkg::dcache_rtrn_t dcache_rtrn_o,
  // wishbone
  output cache_bus_pkg::wb_req_t      wb_o,
  input  cache_bus_pkg::wb_rsp_t      wb_i
);
  import cache_bus_pkg::*;

  icache_req_t       ic_head;
  dcache_req_t       dc_head;
  logic              ic_full;
  logic              ic_empty;
  logic              ic_pop;
  logic              dc_full;
  logic              dc_empty;
  logic              dc_pop;
  bus_cmd_t          cmd;
  logic              cmd_valid;
  logic              cmd_gnt;
  logic              beat_valid;
  logic [DATA_W-1:0] beat_data;
  logic              beat_last;
  src_e              beat_src;
  logic [TID_W-1:0]  beat_tid;

  ////////////////////////////////////////////////////////////
  // request queues
  ////////////////////////////////////////////////////////////

  assign icache_ack_o = icache_req_i & ~ic_full;
  assign dcache_ack_o = dcache_req_i & ~dc_full;

  req_fifo #(
    .Depth(ReqFifoDepth),
    .dtype(icache_req_t)
  ) i_icache_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (icache_ack_o),
    .data_i (icache_data_i),
    .full_o (ic_full),
    .pop_i  (ic_pop),
    .data_o (ic_head),
    .empty_o(ic_empty)
  );

  req_fifo #(
    .Depth(ReqFifoDepth),
    .dtype(dcache_req_t)
  ) i_dcache_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (dcache_ack_o),
    .data_i (dcache_data_i),
    .full_o (dc_full),
    .pop_i  (dc_pop),
    .data_o (dc_head),
    .empty_o(dc_empty)
  );

  ////////////////////////////////////////////////////////////
  // arbitration, bus and return path
  ////////////////////////////////////////////////////////////

  req_arbiter i_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ic_head_i  (ic_head),
    .ic_empty_i (ic_empty),
    .ic_pop_o   (ic_pop),
    .dc_head_i  (dc_head),
    .dc_empty_i (dc_empty),
    .dc_pop_o   (dc_pop),
    .cmd_o      (cmd),
    .cmd_valid_o(cmd_valid),
    .cmd_gnt_i  (cmd_gnt)
  );

  wb_master i_wb_master (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_gnt_o   (cmd_gnt),
    .wb_o        (wb_o),
    .wb_i        (wb_i),
    .beat_valid_o(beat_valid),
    .beat_data_o (beat_data),
    .beat_last_o (beat_last),
    .beat_src_o  (beat_src),
    .beat_tid_o  (beat_tid)
  );

  // write direction comes straight off the active bus cycle
  rtrn_assembler i_rtrn (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .beat_valid_i     (beat_valid),
    .beat_data_i      (beat_data),
    .beat_last_i      (beat_last),
    .beat_src_i       (beat_src),
    .beat_we_i        (wb_o.we),
    .beat_tid_i       (beat_tid),
    .icache_rtrn_vld_o(icache_rtrn_vld_o),
    .icache_rtrn_o    (icache_rtrn_o),
    .dcache_rtrn_vld_o(dcache_rtrn_vld_o),
    .dcache_rtrn_o    (dcache_rtrn_o)
  );

endmodule

// ==== verilog/rtrn_assembler.sv ====
`timescale 1ns/100ps

module rtrn_assembler (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             beat_valid_i,
  input  logic [cache_bus_pkg::DATA_W-1:0] beat_data_i,
  input  logic                             beat_last_i,
  input  cache_bus_pkg::src_e              beat_src_i,
  input  logic                             beat_we_i,
  input  logic [cache_bus_pkg::TID_W-1:0]  beat_tid_i,
  output logic                             icache_rtrn_vld_o,
  output cache_bus_pkg::icache_rtrn_t      icache_rtrn_o,
  output logic                             dcache_rtrn_vld_o,
  output cache_bus_pkg::dcache_rtrn_t      dcache_rtrn_o
);
  import cache_bus_pkg::*;

  logic [LINE_WORDS-1:0][DATA_W-1:0] line_d;
  logic [LINE_WORDS-1:0][DATA_W-1:0] line_q;
  logic                              first_q;
  logic                              rd_beat;
  logic                              ic_vld_q;
  logic                              dc_vld_q;
  logic [TID_W-1:0]                  tid_q;
  dcache_ack_e                       rtype_q;

  assign rd_beat = beat_valid_i & ~beat_we_i;

  // beats enter at the top word, so beat i ends up at word i
  always_comb begin : p_shift
    line_d = {beat_data_i, line_q[LINE_WORDS-1:1]};
    if (first_q && beat_last_i) begin
      // single-beat read goes to word 0, rest of the line is zero
      line_d    = '0;
      line_d[0] = beat_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      first_q  <= 1'b1;
      ic_vld_q <= 1'b0;
      dc_vld_q <= 1'b0;
    end else begin
      if (rd_beat) begin
        first_q <= beat_last_i;
      end
      ic_vld_q <= beat_valid_i & beat_last_i & (beat_src_i == SRC_ICACHE);
      dc_vld_q <= beat_valid_i & beat_last_i & (beat_src_i == SRC_DCACHE);
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (rd_beat) begin
      line_q <= line_d;
    end
    if (beat_valid_i && beat_last_i) begin
      tid_q   <= beat_tid_i;
      rtype_q <= beat_we_i ? DC_STORE_ACK : DC_LOAD_ACK;
    end
  end

  // packets are only meaningful while their valid is up
  always_comb begin : p_out
    icache_rtrn_vld_o   = ic_vld_q;
    icache_rtrn_o.tid   = tid_q;
    icache_rtrn_o.data  = line_q;
    dcache_rtrn_vld_o   = dc_vld_q;
    dcache_rtrn_o.rtype = rtype_q;
    dcache_rtrn_o.tid   = tid_q;
    dcache_rtrn_o.data  = line_q;
  end

endmodule

// ==== verilog/wb_master.sv ====
`timescale 1ns/100ps

module wb_master (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  cache_bus_pkg::bus_cmd_t           cmd_i,
  input  logic                              cmd_valid_i,
  output logic                              cmd_gnt_o,
  output cache_bus_pkg::wb_req_t            wb_o,
  input  cache_bus_pkg::wb_rsp_t            wb_i,
  output logic                              beat_valid_o,
  output logic [cache_bus_pkg::DATA_W-1:0]  beat_data_o,
  output logic                              beat_last_o,
  output cache_bus_pkg::src_e               beat_src_o,
  output logic [cache_bus_pkg::TID_W-1:0]   beat_tid_o
);
  import cache_bus_pkg::*;

  typedef enum logic {IDLE, BUSY} state_e;

  state_e            state_q;
  logic [BEAT_W-1:0] cnt_q;
  logic [ADDR_W-1:0] adr_q;
  bus_cmd_t          cmd_q;
  logic              beat_ack;
  logic              last_beat;

  assign cmd_gnt_o = cmd_valid_i & (state_q == IDLE);
  assign beat_ack  = (state_q == BUSY) & wb_i.ack;
  assign last_beat = (cnt_q == BEAT_W'(1));

  ////////////////////////////////////////////////////////////
  // wishbone outputs
  ////////////////////////////////////////////////////////////

  // cyc and stb stay up across all beats of a fill
  always_comb begin : p_wb
    wb_o     = '0;
    wb_o.cyc = (state_q == BUSY);
    wb_o.stb = (state_q == BUSY);
    wb_o.we  = cmd_q.we;
    wb_o.adr = adr_q;
    wb_o.sel = cmd_q.sel;
    wb_o.dat = cmd_q.wdata;
  end

  // beat report towards the return stage
  assign beat_valid_o = beat_ack;
  assign beat_data_o  = wb_i.dat;
  assign beat_last_o  = last_beat;
  assign beat_src_o   = cmd_q.src;
  assign beat_tid_o   = cmd_q.tid;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fsm
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (cmd_gnt_o) begin
            state_q <= BUSY;
            cnt_q   <= cmd_i.beats;
          end
        end
        BUSY: begin
          if (beat_ack) begin
            cnt_q <= cnt_q - 1'b1;
            if (last_beat) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (cmd_gnt_o) begin
      cmd_q <= cmd_i;
      adr_q <= cmd_i.addr;
    end else if (beat_ack) begin
      // next word of the line
      adr_q <= adr_q + ADDR_W'(DATA_W / 8);
    end
  end

endmodule

// ==== verilog/req_arbiter.sv ====
`timescale 1ns/100ps

module req_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  cache_bus_pkg::icache_req_t ic_head_i,
  input  logic                       ic_empty_i,
  output logic                       ic_pop_o,
  input  cache_bus_pkg::dcache_req_t dc_head_i,
  input  logic                       dc_empty_i,
  output logic                       dc_pop_o,
  output cache_bus_pkg::bus_cmd_t    cmd_o,
  output logic                       cmd_valid_o,
  input  logic                       cmd_gnt_i
);
  import cache_bus_pkg::*;

  localparam int unsigned LineOffW = $clog2(LINE_W / 8);
  localparam int unsigned WordOffW = $clog2(DATA_W / 8);

  src_e prio_q;
  src_e lock_src_q;
  src_e sel_src;
  logic lock_q;

  ////////////////////////////////////////////////////////////
  // port selection
  ////////////////////////////////////////////////////////////

  // a locked offer keeps its port until the master takes it
  always_comb begin : p_pick
    if (lock_q) begin
      sel_src = lock_src_q;
    end else if (!ic_empty_i && !dc_empty_i) begin
      sel_src = prio_q;
    end else if (!dc_empty_i) begin
      sel_src = SRC_DCACHE;
    end else begin
      sel_src = SRC_ICACHE;
    end
  end

  assign cmd_valid_o = lock_q | ~ic_empty_i | ~dc_empty_i;
  assign ic_pop_o    = cmd_gnt_i & (sel_src == SRC_ICACHE);
  assign dc_pop_o    = cmd_gnt_i & (sel_src == SRC_DCACHE);

  ////////////////////////////////////////////////////////////
  // command build
  ////////////////////////////////////////////////////////////

  always_comb begin : p_cmd
    cmd_o       = '0;
    cmd_o.src   = sel_src;
    cmd_o.sel   = '1;
    cmd_o.beats = BEAT_W'(1);
    if (sel_src == SRC_ICACHE) begin
      cmd_o.tid = ic_head_i.tid;
      if (ic_head_i.nc) begin
        cmd_o.addr = {ic_head_i.paddr[ADDR_W-1:WordOffW], {WordOffW{1'b0}}};
      end else begin
        // line fill starts at the aligned address
        cmd_o.addr  = {ic_head_i.paddr[ADDR_W-1:LineOffW], {LineOffW{1'b0}}};
        cmd_o.beats = BEAT_W'(LINE_WORDS);
      end
    end else begin
      cmd_o.tid  = dc_head_i.tid;
      cmd_o.addr = {dc_head_i.paddr[ADDR_W-1:WordOffW], {WordOffW{1'b0}}};
      if (dc_head_i.rtype == DC_STORE) begin
        // store data already sits in its byte lanes
        cmd_o.we    = 1'b1;
        cmd_o.wdata = dc_head_i.data;
        unique case (dc_head_i.size)
          2'b00: cmd_o.sel = SEL_W'(1) << dc_head_i.paddr[WordOffW-1:0];
          2'b01: cmd_o.sel = SEL_W'(3) << (dc_head_i.paddr[WordOffW-1:0] & ~WordOffW'(1));
          default: cmd_o.sel = '1;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      prio_q     <= SRC_ICACHE;
      lock_q     <= 1'b0;
      lock_src_q <= SRC_ICACHE;
    end else begin
      if (cmd_gnt_i) begin
        lock_q <= 1'b0;
        // the other port wins the next tie
        prio_q <= (sel_src == SRC_ICACHE) ? SRC_DCACHE : SRC_ICACHE;
      end else if (cmd_valid_o) begin
        lock_q     <= 1'b1;
        lock_src_q <= sel_src;
      end
    end
  end

endmodule

// ==== verilog/req_fifo.sv ====
`timescale 1ns/100ps

module req_fifo #(
  parameter int unsigned Depth = 2,
  parameter type dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  output logic full_o,
  input  logic pop_i,
  output dtype data_o,
  output logic empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  dtype            mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== verilog/cache_bus_pkg.sv ====
package cache_bus_pkg;

  // bus and line geometry
  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned DATA_W         = 32;
  localparam int unsigned LINE_W         = 128;
  localparam int unsigned LINE_WORDS     = LINE_W / DATA_W;
  localparam int unsigned TID_W          = 4;
  localparam int unsigned REQ_FIFO_DEPTH = 2;
  // beat counter has to hold LINE_WORDS itself
  localparam int unsigned BEAT_W         = $clog2(LINE_WORDS + 1);
  localparam int unsigned SEL_W          = DATA_W / 8;

  typedef enum logic {SRC_ICACHE, SRC_DCACHE} src_e;
  typedef enum logic {DC_LOAD, DC_STORE} dcache_op_e;
  typedef enum logic {DC_LOAD_ACK, DC_STORE_ACK} dcache_ack_e;

  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
    logic [TID_W-1:0]  tid;
  } icache_req_t;

  typedef struct packed {
    dcache_op_e        rtype;
    logic [ADDR_W-1:0] paddr;
    // 0 byte, 1 half, 2 word
    logic [1:0]        size;
    logic [DATA_W-1:0] data;
    logic [TID_W-1:0]  tid;
  } dcache_req_t;

  typedef struct packed {
    logic [TID_W-1:0]  tid;
    logic [LINE_W-1:0] data;
  } icache_rtrn_t;

  typedef struct packed {
    dcache_ack_e       rtype;
    logic [TID_W-1:0]  tid;
    logic [LINE_W-1:0] data;
  } dcache_rtrn_t;

  typedef struct packed {
    src_e              src;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] wdata;
    logic [BEAT_W-1:0] beats;
    logic [TID_W-1:0]  tid;
  } bus_cmd_t;

  // wishbone classic, master side
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage
